// File: run_sim.sh
#!/bin/sh
# build the DL11 testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_dl11 \
   -f sim.f -o tb_dl11 || { echo "run_sim: build failed"; exit 1; }
out=$(./obj_dir/tb_dl11)
echo "$out"
echo "$out" | grep -qx "TEST OK" && echo "run_sim: passed" \
   || { echo "run_sim: failed"; exit 1; }

// File: sim.f
source/dl11_pkg.sv
source/baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/dl11_regs.sv
source/dl11_top.sv
tb/dl11_properties.sv
tb/tb_dl11.sv

// File: source/baud_gen.sv
/* Oversample tick generator, one clk wide pulse every clks_per_tick clocks.
   The serial bit time is os_rate ticks. clks_per_tick must be at least 1. */
`timescale 1ns/10ps

module baud_gen #(
   parameter int clks_per_tick = 4
) (
   input  logic clk,
   input  logic reset,
   output logic os_tick
);

   localparam int cnt_w = (clks_per_tick > 1) ? $clog2(clks_per_tick) : 1;
   localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_tick - 1);

   logic [cnt_w-1:0] count;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count   <= '0;
         os_tick <= 1'b0;
      end
      else if (count == cnt_last)
      begin
         count   <= '0;
         os_tick <= 1'b1;   // wrap marks the tick
      end
      else
      begin
         count   <= count + 1'b1;
         os_tick <= 1'b0;
      end
   end

endmodule

// File: source/dl11_pkg.sv
/* Shared constants and state types for the DL11 console interface.
   Register offsets are byte offsets from the device base in the I/O page.
   Both CSRs place done and interrupt enable at the same bit positions. */
package dl11_pkg;

   // register offsets from csr_base, even word addresses
   parameter logic [12:0] rcsr_off = 13'd0;
   parameter logic [12:0] rbuf_off = 13'd2;
   parameter logic [12:0] xcsr_off = 13'd4;
   parameter logic [12:0] xbuf_off = 13'd6;

   // csr bit positions, same in rcsr and xcsr
   parameter int csr_done_bit = 7;
   parameter int csr_ie_bit   = 6;

   // vector offsets from vector_base
   parameter logic [7:0] rx_vec_off = 8'd0;   // receiver, higher priority
   parameter logic [7:0] tx_vec_off = 8'd4;

   // ticks per bit time on the serial line
   parameter int os_rate = 16;

   // transmitter handshake towards uart_tx
   typedef enum logic [1:0] {
      tto_ready,   // xcsr done set, waiting for xbuf write
      tto_send,    // waiting for uart_tx to go idle
      tto_wait     // frame in flight
   } tto_state_t;

   // receive buffer
   typedef enum logic {
      tti_empty,
      tti_full
   } tti_state_t;

   // receiver line states
   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_t;

   // transmitter line states
   typedef enum logic [1:0] {
      tx_idle,
      tx_start,
      tx_data,
      tx_stop
   } tx_state_t;

endpackage

// File: source/dl11_regs.sv
/* DL11 register block with RCSR, RBUF, XCSR and XBUF at csr_base + 0, 2, 4 and 6.
   Reads are combinational and gated by bus_rd, writes land on the clock edge.
   An unread received byte is overwritten by the next one, no overrun flag.
   A byte write to the odd XBUF address sends data_in[15:8]. */
`timescale 1ns/10ps

module dl11_regs #(
   parameter logic [12:0] csr_base    = 13'o17560,
   parameter logic [7:0]  vector_base = 8'o60
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [12:0] bus_addr,
   input  logic [15:0] data_in,
   input  logic        bus_rd,
   input  logic        bus_wr,
   input  logic        bus_byte_op,
   input  logic        interrupt_ack,
   input  logic        tx_busy,
   input  logic        rx_valid,
   input  logic [7:0]  rx_data,
   output logic [15:0] data_out,
   output logic        decode,
   output logic        interrupt,
   output logic [7:0]  vector,
   output logic        tx_start,
   output logic [7:0]  tx_data
);

   import dl11_pkg::*;

   logic [12:0] offset;
   logic [12:0] word_off;
   logic [15:0] reg_out;
   logic [15:0] reg_in;
   logic [15:0] xbuf;
   logic [7:0]  rbuf;
   logic        lo_lane;
   logic        rcsr_wr, xcsr_wr, xbuf_wr, rbuf_rd;
   logic        rx_int_enable, tx_int_enable;
   logic        rx_int, tx_int;
   logic        rx_pending, tx_pending;
   logic        rx_done, tx_done;
   logic        assert_rx_int, assert_tx_int;
   logic        clear_rx_int, clear_tx_int;
   tto_state_t  tto_state;
   tti_state_t  tti_state;

   // eight byte addresses from csr_base
   assign offset   = bus_addr - csr_base;
   assign decode   = (offset < 13'd8);
   assign word_off = {offset[12:1], 1'b0};

   always_comb
   begin
      reg_out = '0;
      case (word_off)
         rcsr_off:
         begin
            reg_out[csr_done_bit] = rx_done;
            reg_out[csr_ie_bit]   = rx_int_enable;
         end
         rbuf_off: reg_out[7:0] = rbuf;
         xcsr_off:
         begin
            reg_out[csr_done_bit] = tx_done;
            reg_out[csr_ie_bit]   = tx_int_enable;
         end
         xbuf_off: reg_out = xbuf;
         default: reg_out = '0;
      endcase
   end

   // byte reads come back in the low lane
   assign data_out = !(bus_rd && decode) ? 16'b0 :
                     !bus_byte_op        ? reg_out :
                     {8'b0, bus_addr[0] ? reg_out[15:8] : reg_out[7:0]};

   assign reg_in  = (bus_byte_op && bus_addr[0]) ? {8'b0, data_in[15:8]} : data_in;
   assign lo_lane = !(bus_byte_op && bus_addr[0]);   // csr bits live in low byte

   assign rcsr_wr = bus_wr && decode && (word_off == rcsr_off) && lo_lane;
   assign xcsr_wr = bus_wr && decode && (word_off == xcsr_off) && lo_lane;
   assign xbuf_wr = bus_wr && decode && (word_off == xbuf_off);
   assign rbuf_rd = bus_rd && decode && (word_off == rbuf_off);   // word or byte

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         xbuf          <= '0;
         rx_int_enable <= 1'b0;
         tx_int_enable <= 1'b0;
      end
      else
      begin
         if (rcsr_wr)
            rx_int_enable <= reg_in[csr_ie_bit];
         if (xcsr_wr)
            tx_int_enable <= reg_in[csr_ie_bit];
         if (xbuf_wr)
            xbuf <= reg_in;   // also while busy, only the buffer changes
      end
   end

   always_ff @(posedge clk)
   begin
      if (rx_valid)
         rbuf <= rx_data;
   end

   // done drops after the xbuf write, start pulse a cycle later
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tto_state <= tto_ready;
         tx_start  <= 1'b0;
      end
      else
      begin
         tx_start <= 1'b0;
         case (tto_state)
            tto_ready:
               if (xbuf_wr)
                  tto_state <= tto_send;
            tto_send:
               if (!tx_busy)
               begin
                  tx_start  <= 1'b1;
                  tto_state <= tto_wait;
               end
            tto_wait:   // busy is still low while the start pulse is out
               if (!tx_busy && !tx_start)
                  tto_state <= tto_ready;
            default: tto_state <= tto_ready;
         endcase
      end
   end

   assign tx_data = xbuf[7:0];
   assign tx_done = (tto_state == tto_ready);

   always_ff @(posedge clk)
   begin
      if (reset)
         tti_state <= tti_empty;
      else if (rx_valid)
         tti_state <= tti_full;   // wins over a read in the same cycle
      else if (rbuf_rd)
         tti_state <= tti_empty;
   end

   assign rx_done = (tti_state == tti_full);

   // requests latch regardless of enable, the enables gate what is shown
   assign rx_pending = rx_int && rx_int_enable;
   assign tx_pending = tx_int && tx_int_enable;

   assign assert_tx_int = (tto_state == tto_wait) && !tx_busy && !tx_start;
   assign assert_rx_int = rx_valid ||
                          (rcsr_wr && reg_in[csr_ie_bit] && !rx_int_enable && rx_done);
   assign clear_rx_int  = (interrupt_ack && rx_pending) || rbuf_rd;
   assign clear_tx_int  = (interrupt_ack && tx_pending && !rx_pending) || xbuf_wr;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_int <= 1'b0;
         tx_int <= 1'b0;
      end
      else
      begin
         if (assert_rx_int)
            rx_int <= 1'b1;
         else if (clear_rx_int)
            rx_int <= 1'b0;

         if (assert_tx_int)
            tx_int <= 1'b1;
         else if (clear_tx_int)
            tx_int <= 1'b0;
      end
   end

   assign interrupt = rx_pending || tx_pending;
   assign vector    = rx_pending ? vector_base + rx_vec_off :   // receiver first
                      tx_pending ? vector_base + tx_vec_off :
                      8'b0;

endmodule

// File: source/dl11_top.sv
/* DL11 console interface top, single clk domain.
   Baud rate is clk / (clks_per_tick * 16), csr_base must be 8 byte aligned. */
`timescale 1ns/10ps

module dl11_top #(
   parameter logic [12:0] csr_base      = 13'o17560,
   parameter logic [7:0]  vector_base   = 8'o60,
   parameter int          clks_per_tick = 4
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [12:0] bus_addr,
   input  logic [15:0] data_in,
   input  logic        bus_rd,
   input  logic        bus_wr,
   input  logic        bus_byte_op,
   output logic [15:0] data_out,
   output logic        decode,
   output logic        interrupt,
   input  logic        interrupt_ack,
   output logic [7:0]  vector,
   output logic        rs232_tx,
   input  logic        rs232_rx
);

   logic       os_tick;
   logic       tx_start;
   logic [7:0] tx_data;
   logic       tx_busy;
   logic       rx_valid;
   logic [7:0] rx_data;

   dl11_regs #(
      .csr_base    (csr_base),
      .vector_base (vector_base)
   ) regs (
      .clk           (clk),
      .reset         (reset),
      .bus_addr      (bus_addr),
      .data_in       (data_in),
      .bus_rd        (bus_rd),
      .bus_wr        (bus_wr),
      .bus_byte_op   (bus_byte_op),
      .interrupt_ack (interrupt_ack),
      .tx_busy       (tx_busy),
      .rx_valid      (rx_valid),
      .rx_data       (rx_data),
      .data_out      (data_out),
      .decode        (decode),
      .interrupt     (interrupt),
      .vector        (vector),
      .tx_start      (tx_start),
      .tx_data       (tx_data)
   );

   baud_gen #(
      .clks_per_tick (clks_per_tick)
   ) brg (
      .clk     (clk),
      .reset   (reset),
      .os_tick (os_tick)
   );

   // both halves share the oversample tick
   uart_tx tx (
      .clk      (clk),
      .reset    (reset),
      .os_tick  (os_tick),
      .tx_start (tx_start),
      .tx_data  (tx_data),
      .tx_busy  (tx_busy),
      .tx_out   (rs232_tx)
   );

   uart_rx rx (
      .clk      (clk),
      .reset    (reset),
      .os_tick  (os_tick),
      .rx_in    (rs232_rx),
      .rx_valid (rx_valid),
      .rx_data  (rx_data)
   );

endmodule

// File: source/uart_rx.sv
/* 8N1 receiver with os_rate oversampling and a two flop line synchronizer.
   The start bit is rechecked at mid-bit, data and stop are sampled at mid-bit.
   A frame with a low stop bit is dropped and no rx_valid is given for it. */
`timescale 1ns/10ps

module uart_rx (
   input  logic       clk,
   input  logic       reset,
   input  logic       os_tick,
   input  logic       rx_in,
   output logic       rx_valid,
   output logic [7:0] rx_data
);

   import dl11_pkg::*;

   localparam int tick_w = $clog2(os_rate);
   localparam logic [tick_w-1:0] tick_last = tick_w'(os_rate - 1);
   localparam logic [tick_w-1:0] tick_half = tick_w'(os_rate / 2 - 1);

   logic              rx_meta;
   logic              rx_sync;
   rx_state_t         state;
   logic [tick_w-1:0] tick_cnt;
   logic [2:0]        bit_idx;
   logic [7:0]        shift;
   logic              bit_end;

   // line idles high, so the synchronizer resets to mark
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end
      else
      begin
         rx_meta <= rx_in;
         rx_sync <= rx_meta;
      end
   end

   assign bit_end = os_tick && (tick_cnt == tick_last);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= rx_idle;
         tick_cnt <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end
      else
      begin
         rx_valid <= 1'b0;
         if (os_tick && state != rx_idle)
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;

         case (state)
            rx_idle:
               if (os_tick && !rx_sync)
               begin
                  state    <= dl11_pkg::rx_start;   // falling edge seen
                  tick_cnt <= '0;
               end
            dl11_pkg::rx_start:
               if (os_tick && tick_cnt == tick_half)
               begin
                  if (!rx_sync)
                  begin
                     state    <= dl11_pkg::rx_data;
                     tick_cnt <= '0;   // from here bit_end lands mid-bit
                     bit_idx  <= '0;
                  end
                  else
                     state <= rx_idle;   // glitch, not a start bit
               end
            dl11_pkg::rx_data:
               if (bit_end)
               begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= rx_stop;
               end
            rx_stop:
               if (bit_end)
               begin
                  state    <= rx_idle;
                  rx_valid <= rx_sync;   // framing error drops the byte
               end
            default: state <= rx_idle;
         endcase
      end
   end

   // lsb arrives first, shifted in from the top
   always_ff @(posedge clk)
   begin
      if (state == dl11_pkg::rx_data && bit_end)
         shift <= {rx_sync, shift[7:1]};
   end

   assign rx_data = shift;

endmodule

// File: source/uart_tx.sv
/* 8N1 serializer, LSB first, one bit per os_rate oversample ticks.
   tx_start is taken only while idle, and tx_busy rises the cycle after it.
   The start bit may run up to one tick short since ticks are free running. */
`timescale 1ns/10ps

module uart_tx (
   input  logic       clk,
   input  logic       reset,
   input  logic       os_tick,
   input  logic       tx_start,
   input  logic [7:0] tx_data,
   output logic       tx_busy,
   output logic       tx_out
);

   import dl11_pkg::*;

   localparam int tick_w = $clog2(os_rate);
   localparam logic [tick_w-1:0] tick_last = tick_w'(os_rate - 1);

   tx_state_t         state;
   logic [tick_w-1:0] tick_cnt;
   logic [2:0]        bit_idx;
   logic [7:0]        shift;
   logic              bit_end;

   assign bit_end = os_tick && (tick_cnt == tick_last);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= tx_idle;
         tick_cnt <= '0;
         bit_idx  <= '0;
      end
      else
      begin
         if (state == tx_idle || bit_end)
            tick_cnt <= '0;                 // each bit restarts the count
         else if (os_tick)
            tick_cnt <= tick_cnt + 1'b1;

         case (state)
            tx_idle:
               if (tx_start)
                  state <= dl11_pkg::tx_start;
            dl11_pkg::tx_start:
               if (bit_end)
               begin
                  state   <= dl11_pkg::tx_data;
                  bit_idx <= '0;
               end
            dl11_pkg::tx_data:
               if (bit_end)
               begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= tx_stop;
               end
            tx_stop:
               if (bit_end)
                  state <= tx_idle;
            default: state <= tx_idle;
         endcase
      end
   end

   // data shifts right so bit 0 is always the one on the line
   always_ff @(posedge clk)
   begin
      if (state == tx_idle && tx_start)
         shift <= tx_data;
      else if (state == dl11_pkg::tx_data && bit_end)
         shift <= {1'b1, shift[7:1]};
   end

   assign tx_busy = (state != tx_idle);
   assign tx_out  = (state == dl11_pkg::tx_start) ? 1'b0 :
                    (state == dl11_pkg::tx_data)  ? shift[0] :
                    1'b1;                  // idle and stop are mark

endmodule

// File: tb/dl11_properties.sv
/* Concurrent checks on the DL11 register block, bound into dl11_regs.
   vector_base must match the value the register block was built with. */
`timescale 1ns/10ps

module dl11_properties #(
   parameter logic [7:0] vector_base = 8'o60
) (
   input logic       clk,
   input logic       reset,
   input logic       interrupt,
   input logic       rx_int_enable,
   input logic       rx_done,
   input logic       tx_done,
   input logic       tx_int,
   input logic       tx_start,
   input logic       tx_busy,
   input logic [7:0] vector
);

   import dl11_pkg::*;

   // done and the request come back the cycle after the line goes idle
   tx_done_after_busy: assert property (@(posedge clk) disable iff (reset)
      $fell(tx_busy) |=> (tx_done && tx_int))
      else $error("xcsr done or transmitter request missing after the frame ended");

   start_while_idle: assert property (@(posedge clk) disable iff (reset)
      tx_start |-> !tx_busy)
      else $error("tx_start pulsed while the transmitter was busy");

   // enabling with a byte waiting shows the receiver vector at once
   rx_enable_vector: assert property (@(posedge clk) disable iff (reset)
      ($rose(rx_int_enable) && $past(rx_done)) |->
         (interrupt && (vector == vector_base + rx_vec_off)))
      else $error("receiver request not shown on enable, vector is %h", vector);

endmodule

// File: tb/tb_dl11.sv
/* Directed testbench for dl11_top with clks_per_tick 4, so one bit time is 64 clocks.
   Bus inputs change on the rising edge, outputs are sampled on the falling edge.
   The serial line models assume 8N1 and the default csr_base. */
`timescale 1ns/10ps

module tb_dl11;

   import dl11_pkg::*;

   localparam logic [12:0] csr_base = 13'o17560;
   localparam int bit_clks       = 4 * os_rate;
   localparam int frame_clks     = 10 * bit_clks;
   localparam int test_frames    = 10;   // all tests together run about this many frames
   localparam int timeout_cycles = 4 * test_frames * frame_clks;

   logic        clk;
   logic        reset;
   logic [12:0] bus_addr;
   logic [15:0] data_in;
   logic        bus_rd;
   logic        bus_wr;
   logic        bus_byte_op;
   logic        interrupt_ack;
   logic        rs232_rx;
   logic [15:0] data_out;
   logic        decode;
   logic        interrupt;
   logic [7:0]  vector;
   logic        rs232_tx;

   int errors = 0;
   int checks = 0;
   int cycle_count = 0;

   dl11_top #(
      .csr_base      (csr_base),
      .vector_base   (8'o60),
      .clks_per_tick (4)
   ) DUT (
      .clk           (clk),
      .reset         (reset),
      .bus_addr      (bus_addr),
      .data_in       (data_in),
      .bus_rd        (bus_rd),
      .bus_wr        (bus_wr),
      .bus_byte_op   (bus_byte_op),
      .data_out      (data_out),
      .decode        (decode),
      .interrupt     (interrupt),
      .interrupt_ack (interrupt_ack),
      .vector        (vector),
      .rs232_tx      (rs232_tx),
      .rs232_rx      (rs232_rx)
   );

   bind dl11_regs dl11_properties #(.vector_base (vector_base)) props (
      .clk           (clk),
      .reset         (reset),
      .interrupt     (interrupt),
      .rx_int_enable (rx_int_enable),
      .rx_done       (rx_done),
      .tx_done       (tx_done),
      .tx_int        (tx_int),
      .tx_start      (tx_start),
      .tx_busy       (tx_busy),
      .vector        (vector)
   );

   initial
      clk = 1'b0;
   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles)
      begin
         $display("run stopped after %0d cycles without finishing", cycle_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      checks++;
      assert (got == exp)
      else
      begin
         $display("FAILED %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic bus_write(input logic [12:0] addr, input logic [15:0] data,
                            input logic byte_op);
      @(posedge clk);
      bus_addr    <= addr;
      data_in     <= data;
      bus_byte_op <= byte_op;
      bus_wr      <= 1'b1;
      @(posedge clk);
      bus_wr      <= 1'b0;
      bus_byte_op <= 1'b0;
   endtask

   task automatic bus_read(input logic [12:0] addr, input logic byte_op,
                           output logic [15:0] data);
      @(posedge clk);
      bus_addr    <= addr;
      bus_byte_op <= byte_op;
      bus_rd      <= 1'b1;
      @(negedge clk);
      data = data_out;   // combinational read
      @(posedge clk);
      bus_rd      <= 1'b0;
      bus_byte_op <= 1'b0;
   endtask

   task automatic bus_read_check(input logic [12:0] addr, input logic byte_op,
                                 input logic [15:0] exp, input string name);
      logic [15:0] data;
      bus_read(addr, byte_op, data);
      check_value(name, data, exp);
   endtask

   task automatic check_decode(input logic [12:0] addr, input logic exp);
      @(posedge clk);
      bus_addr <= addr;
      bus_rd   <= 1'b1;
      @(negedge clk);
      check_value("decode", 16'(decode), 16'(exp));
      if (!exp)
         check_value("data_out", data_out, 16'h0000);   // nothing driven outside
      @(posedge clk);
      bus_rd <= 1'b0;
   endtask

   // polls a csr until its done bit is set
   task automatic wait_done(input logic [12:0] addr, input string name);
      logic [15:0] csr;
      int polls;
      csr = '0;
      polls = 0;
      while (!csr[csr_done_bit] && polls < frame_clks)
      begin
         bus_read(addr, 1'b0, csr);
         polls++;
      end
      checks++;
      assert (csr[csr_done_bit])
      else
      begin
         $display("%s done bit never came up while polling", name);
         errors++;
      end
   endtask

   task automatic acknowledge();
      @(posedge clk);
      interrupt_ack <= 1'b1;
      @(posedge clk);
      interrupt_ack <= 1'b0;
   endtask

   // start bit, 8 data bits lsb first, then the given stop bit
   task automatic send_serial(input logic [7:0] data, input logic stop_bit);
      logic [9:0] frame;
      frame = {stop_bit, data, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk);
         rs232_rx <= frame[i];
         repeat (bit_clks - 1) @(posedge clk);
      end
      @(posedge clk);
      rs232_rx <= 1'b1;
   endtask

   task automatic capture_serial(output logic [7:0] data, output logic stop_bit,
                                 output logic found);
      int idle_clks;
      idle_clks = 0;
      data = '0;
      stop_bit = 1'b0;
      @(negedge clk);
      while (rs232_tx && idle_clks < 4 * bit_clks)
      begin
         @(negedge clk);
         idle_clks++;
      end
      found = !rs232_tx;
      if (found)
      begin
         repeat (bit_clks / 2) @(negedge clk);   // middle of start bit
         found = !rs232_tx;
         for (int i = 0; i < 8; i++)
         begin
            repeat (bit_clks) @(negedge clk);
            data[i] = rs232_tx;
         end
         repeat (bit_clks) @(negedge clk);
         stop_bit = rs232_tx;
      end
   endtask

   task automatic test_reset_state();
      bus_read_check(csr_base + rcsr_off, 1'b0, 16'h0000, "rcsr");
      bus_read_check(csr_base + xcsr_off, 1'b0, 16'o200, "xcsr");
      @(negedge clk);
      check_value("interrupt", 16'(interrupt), 16'h0);
      check_value("rs232_tx", 16'(rs232_tx), 16'h1);
      check_decode(csr_base + 13'd8, 1'b0);
      check_decode(csr_base - 13'd2, 1'b0);
      check_decode(csr_base + xbuf_off + 13'd1, 1'b1);
   endtask

   task automatic test_transmit(input int n_bytes);
      logic [7:0] sent;
      logic [7:0] extra;
      logic [7:0] got;
      logic       stop_bit;
      logic       found;
      int         low_count;
      for (int n = 0; n < n_bytes; n++)
      begin
         sent = 8'($urandom);
         extra = 8'($urandom);
         bus_write(csr_base + xbuf_off, {8'h00, sent}, 1'b0);
         bus_read_check(csr_base + xcsr_off, 1'b0, 16'h0000, "xcsr during frame");
         bus_write(csr_base + xbuf_off, {8'h00, extra}, 1'b0);   // while busy
         capture_serial(got, stop_bit, found);
         checks++;
         assert (found)
         else
         begin
            $display("no start bit seen on rs232_tx after the xbuf write");
            errors++;
         end
         check_value("rs232_tx data", 16'(got), 16'(sent));
         check_value("rs232_tx stop", 16'(stop_bit), 16'h1);
         wait_done(csr_base + xcsr_off, "xcsr");
         bus_read_check(csr_base + xcsr_off, 1'b0, 16'o200, "xcsr after frame");
         bus_read_check(csr_base + xbuf_off, 1'b0, {8'h00, extra}, "xbuf");
         low_count = 0;
         repeat (2 * bit_clks)
         begin
            @(negedge clk);
            if (!rs232_tx)
               low_count++;
         end
         checks++;
         assert (low_count == 0)
         else
         begin
            $display("a second frame started from the xbuf write made while busy");
            errors++;
         end
      end
   endtask

   task automatic test_receive(input int n_bytes);
      logic [7:0] sent;
      for (int n = 0; n < n_bytes; n++)
      begin
         sent = 8'($urandom);
         send_serial(sent, 1'b1);
         wait_done(csr_base + rcsr_off, "rcsr");
         bus_read_check(csr_base + rbuf_off, 1'b0, {8'h00, sent}, "rbuf");
         bus_read_check(csr_base + rcsr_off, 1'b0, 16'h0000, "rcsr after rbuf read");
         repeat (bit_clks) @(posedge clk);
      end
      send_serial(8'($urandom), 1'b0);   // framing error
      repeat (2 * bit_clks) @(posedge clk);
      bus_read_check(csr_base + rcsr_off, 1'b0, 16'h0000, "rcsr after bad stop bit");
   endtask

   task automatic test_interrupts();
      logic [7:0] rx_byte;
      rx_byte = 8'($urandom);
      send_serial(rx_byte, 1'b1);
      wait_done(csr_base + rcsr_off, "rcsr");
      bus_write(csr_base + xbuf_off, {8'h00, 8'($urandom)}, 1'b0);
      wait_done(csr_base + xcsr_off, "xcsr");
      @(negedge clk);
      check_value("interrupt", 16'(interrupt), 16'h0);   // both held, enables clear
      bus_write(csr_base + xcsr_off, 16'o100, 1'b0);
      bus_write(csr_base + rcsr_off, 16'o100, 1'b0);
      @(negedge clk);
      check_value("interrupt", 16'(interrupt), 16'h1);
      check_value("vector", 16'(vector), 16'o60);
      acknowledge();
      @(negedge clk);
      check_value("interrupt", 16'(interrupt), 16'h1);
      check_value("vector", 16'(vector), 16'o64);
      acknowledge();
      @(negedge clk);
      check_value("interrupt", 16'(interrupt), 16'h0);
      bus_read_check(csr_base + rbuf_off, 1'b0, {8'h00, rx_byte}, "rbuf");
      bus_write(csr_base + rcsr_off, 16'h0000, 1'b0);
      bus_write(csr_base + xcsr_off, 16'h0000, 1'b0);
   endtask

   task automatic test_byte_access();
      logic [15:0] word;
      word = 16'($urandom);
      bus_write(csr_base + xbuf_off, word, 1'b0);
      bus_read_check(csr_base + xbuf_off + 13'd1, 1'b1, {8'h00, word[15:8]},
                     "xbuf high byte");
      wait_done(csr_base + xcsr_off, "xcsr");
      bus_write(csr_base + rcsr_off, 16'o100, 1'b1);   // even address, low lane
      bus_read_check(csr_base + rcsr_off, 1'b0, 16'o100, "rcsr after byte write");
   endtask

   initial
   begin
      void'($urandom(12));
      reset = 1'b1;
      bus_addr = '0;
      data_in = '0;
      bus_rd = 1'b0;
      bus_wr = 1'b0;
      bus_byte_op = 1'b0;
      interrupt_ack = 1'b0;
      rs232_rx = 1'b1;   // line idles at mark
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      test_reset_state();
      test_transmit(2);
      test_receive(2);
      test_interrupts();
      test_byte_access();

      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
